// File: build.f
hdl/core_pkg.sv
hdl/bus_pkg.sv
hdl/reset_sequencer.sv
hdl/cache_warmup_ctrl.sv
hdl/mem_request_router.sv
hdl/writeback_trace.sv
hdl/core_glue_top.sv
verification/core_glue_sva.sv
verification/core_glue_tb.sv

// File: hdl/bus_pkg.sv
package bus_pkg;

    typedef logic [3:0] byteen_t;

    // the codes follow the bus size field.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // the cached port indexes with the virtual address and tags with the physical one.
    typedef struct packed {
        logic            read;
        logic            write;
        byteen_t         byteen;
        core_pkg::word_t vaddr;
        core_pkg::word_t paddr;
        core_pkg::word_t wdata;
    } cached_req_t;

    typedef struct packed {
        logic            read;
        logic            write;
        access_size_e    size;
        byteen_t         byteen;
        core_pkg::word_t paddr;
        core_pkg::word_t wdata;
    } uncached_req_t;

endpackage

// File: hdl/cache_warmup_ctrl.sv
`timescale 1ns/1ps

module cache_warmup_ctrl (
    input  logic Clk,
    input  logic i_core_reset,
    input  logic i_fetch_done,
    input  logic i_dcache_closed,
    output logic o_uncache_all
);
    import core_pkg::*;

    logic [1:0] warmup_cnt;
    logic       cnt_zero;
    logic       icache_closed;

    // ########################################
    // warm-up countdown
    // ########################################

    // fetches are counted down first, and the flag drops one edge after
    // the count has been seen at zero.
    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            warmup_cnt    <= ICACHE_WARMUP_FETCHES;
            cnt_zero      <= 1'b0;
            icache_closed <= 1'b1;
        end else begin
            if (i_fetch_done && warmup_cnt != 2'd0) begin
                warmup_cnt <= warmup_cnt - 2'd1;
            end
            cnt_zero <= (warmup_cnt == 2'd0);
            if (cnt_zero) begin
                icache_closed <= 1'b0;
            end
        end
    end

    assign o_uncache_all = icache_closed | i_dcache_closed;

endmodule

// File: hdl/core_glue_top.sv
`timescale 1ns/1ps

module core_glue_top (
    input  logic                   Clk,
    input  logic                   Myreset,
    input  logic                   i_fetch_done,
    input  logic                   i_dcache_closed,
    input  core_pkg::mem_req_t     i_req,
    input  logic                   i_uncached,
    input  logic                   i_exception,
    input  core_pkg::wb_t          i_wb,
    input  logic                   i_flush,
    input  logic                   i_dm_stall,
    output logic                   o_core_reset,
    output logic                   o_uncache_all,
    output bus_pkg::cached_req_t   o_cached,
    output bus_pkg::uncached_req_t o_uncached,
    output core_pkg::cache_op_e    o_cache_op,
    output logic                   o_align_err,
    output core_pkg::trace_t       o_trace
);

    reset_sequencer u_reset_sequencer (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .o_core_reset (o_core_reset)
    );

    // the warm-up and the trace run on the stretched core reset.
    cache_warmup_ctrl u_cache_warmup_ctrl (
        .Clk             (Clk),
        .i_core_reset    (o_core_reset),
        .i_fetch_done    (i_fetch_done),
        .i_dcache_closed (i_dcache_closed),
        .o_uncache_all   (o_uncache_all)
    );

    mem_request_router u_mem_request_router (
        .i_req         (i_req),
        .i_uncached    (i_uncached),
        .i_exception   (i_exception),
        .i_uncache_all (o_uncache_all),
        .o_cached      (o_cached),
        .o_uncached    (o_uncached),
        .o_cache_op    (o_cache_op),
        .o_align_err   (o_align_err)
    );

    writeback_trace u_writeback_trace (
        .Clk          (Clk),
        .i_core_reset (o_core_reset),
        .i_wb         (i_wb),
        .i_flush      (i_flush),
        .i_dm_stall   (i_dm_stall),
        .i_exception  (i_exception),
        .o_trace      (o_trace)
    );

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;

    // execute-stage memory opcodes.
    typedef enum logic [3:0] {
        OP_NONE  = 4'd0,
        OP_LB    = 4'd1,
        OP_LBU   = 4'd2,
        OP_LH    = 4'd3,
        OP_LHU   = 4'd4,
        OP_LW    = 4'd5,
        OP_LL    = 4'd6,
        OP_SB    = 4'd7,
        OP_SH    = 4'd8,
        OP_SW    = 4'd9,
        OP_SC    = 4'd10,
        OP_CACHE = 4'd11
    } mem_op_e;

    // the codes match the two-bit request the cache expects.
    typedef enum logic [1:0] {
        COP_NONE             = 2'd0,
        COP_INDEX_INVALIDATE = 2'd1,
        COP_STORE_TAG        = 2'd2,
        COP_HIT_WRITEBACK    = 2'd3
    } cache_op_e;

    typedef struct packed {
        mem_op_e    op;
        word_t      vaddr;
        word_t      paddr;
        word_t      wdata;
        logic [2:0] cache_field;
    } mem_req_t;

    typedef struct packed {
        logic    wen;
        reg_id_t reg_id;
        word_t   data;
        word_t   pc;
    } wb_t;

    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;
        reg_id_t    wnum;
        word_t      wdata;
    } trace_t;

    localparam int         RESET_HOLD_CYCLES     = 128;
    localparam logic [1:0] ICACHE_WARMUP_FETCHES = 2'd3;
    localparam logic [2:0] CACHE_FIELD_INDEX_INV = 3'd0;
    localparam logic [2:0] CACHE_FIELD_STORE_TAG = 3'd2;

endpackage

// File: hdl/mem_request_router.sv
`timescale 1ns/1ps

module mem_request_router (
    input  core_pkg::mem_req_t     i_req,
    input  logic                   i_uncached,
    input  logic                   i_exception,
    input  logic                   i_uncache_all,
    output bus_pkg::cached_req_t   o_cached,
    output bus_pkg::uncached_req_t o_uncached,
    output core_pkg::cache_op_e    o_cache_op,
    output logic                   o_align_err
);
    import core_pkg::*;
    import bus_pkg::*;

    logic         is_load;
    logic         is_store;
    logic         misaligned;
    logic         issue;
    logic         to_uncached;
    logic [1:0]   offset;
    access_size_e size;
    byteen_t      byteen;
    word_t        lane_data;

    // ########################################
    // opcode class and access shape
    // ########################################

    assign is_load  = i_req.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LL};
    assign is_store = i_req.op inside {OP_SB, OP_SH, OP_SW, OP_SC};
    assign offset   = i_req.vaddr[1:0];

    assign size = (i_req.op inside {OP_LW, OP_LL, OP_SW, OP_SC}) ? SIZE_WORD :
                  (i_req.op inside {OP_LH, OP_LHU, OP_SH})       ? SIZE_HALF :
                                                                   SIZE_BYTE;

    always_comb begin
        case (size)
            SIZE_WORD: begin
                byteen    = 4'b1111;
                lane_data = i_req.wdata;
            end
            SIZE_HALF: begin
                byteen    = 4'b0011 << offset;
                lane_data = {2{i_req.wdata[15:0]}};
            end
            default: begin
                byteen    = 4'b0001 << offset;
                lane_data = {4{i_req.wdata[7:0]}};
            end
        endcase
    end

    assign misaligned  = (size == SIZE_WORD && offset != 2'd0) ||
                         (size == SIZE_HALF && offset[0]);
    assign o_align_err = (is_load | is_store) & misaligned;

    // ########################################
    // port steering
    // ########################################

    assign issue       = (is_load | is_store) & !misaligned & !i_exception;
    assign to_uncached = i_uncached | i_uncache_all;

    always_comb begin
        o_cached   = '0;
        o_uncached = '0;
        if (issue && to_uncached) begin
            o_uncached.read   = is_load;
            o_uncached.write  = is_store;
            o_uncached.size   = size;
            o_uncached.byteen = byteen;
            o_uncached.paddr  = i_req.paddr;
            o_uncached.wdata  = lane_data;
        end else if (issue) begin
            o_cached.read   = is_load;
            o_cached.write  = is_store;
            o_cached.byteen = byteen;
            o_cached.vaddr  = i_req.vaddr;
            o_cached.paddr  = i_req.paddr;
            o_cached.wdata  = lane_data;
        end
    end

    // every field other than the two known ones is treated as a hit writeback.
    always_comb begin
        o_cache_op = COP_NONE;
        if (i_req.op == OP_CACHE) begin
            case (i_req.cache_field)
                CACHE_FIELD_INDEX_INV: o_cache_op = COP_INDEX_INVALIDATE;
                CACHE_FIELD_STORE_TAG: o_cache_op = COP_STORE_TAG;
                default:               o_cache_op = COP_HIT_WRITEBACK;
            endcase
        end
    end

endmodule

// File: hdl/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
    input  logic Clk,
    input  logic Myreset,
    output logic o_core_reset
);
    import core_pkg::*;

    logic [$clog2(RESET_HOLD_CYCLES)-1:0] hold_cnt;
    logic                                 released;

    // the counter runs only between the external release and the wrap.
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            hold_cnt <= '0;
            released <= 1'b0;
        end else if (!released) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (&hold_cnt) begin
                released <= 1'b1;
            end
        end
    end

    assign o_core_reset = Myreset | !released;

endmodule

// File: hdl/writeback_trace.sv
`timescale 1ns/1ps

module writeback_trace (
    input  logic             Clk,
    input  logic             i_core_reset,
    input  core_pkg::wb_t    i_wb,
    input  logic             i_flush,
    input  logic             i_dm_stall,
    input  logic             i_exception,
    output core_pkg::trace_t o_trace
);
    import core_pkg::*;

    wb_t    wb_masked;
    logic   wen_gated;
    trace_t trace_next;

    // a flushed writeback never reaches the trace.
    assign wb_masked = i_flush ? '0 : i_wb;

    // a stalled write is shown once the stall clears, unless an exception retires it now.
    assign wen_gated = wb_masked.wen & (!i_dm_stall | i_exception);

    always_comb begin
        trace_next.pc    = wb_masked.pc;
        trace_next.wen   = {4{wen_gated}};
        trace_next.wnum  = wb_masked.reg_id;
        trace_next.wdata = wb_masked.data;
    end

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            o_trace <= '0;
        end else begin
            o_trace <= trace_next;
        end
    end

endmodule

// File: verification/core_glue_sva.sv
`timescale 1ns/1ps

module core_glue_sva (
    input logic                   Clk,
    input logic                   i_core_reset,
    input logic                   i_exception,
    input bus_pkg::cached_req_t   i_cached,
    input bus_pkg::uncached_req_t i_uncached,
    input logic                   i_icache_closed
);

    logic cached_issue;
    logic uncached_issue;

    assign cached_issue   = i_cached.read | i_cached.write;
    assign uncached_issue = i_uncached.read | i_uncached.write;

    // ########################################
    // router and warm-up properties
    // ########################################

    a_one_port: assert property (@(posedge Clk) !(cached_issue && uncached_issue))
        else $error("both memory ports issued in the same cycle");

    a_no_issue_on_exception: assert property (@(posedge Clk)
        i_exception |-> !(cached_issue || uncached_issue))
        else $error("a memory request was issued during an exception");

    // once the instruction cache opens it stays open until the next core reset.
    a_icache_stays_open: assert property (@(posedge Clk) disable iff (i_core_reset)
        !i_icache_closed |=> !i_icache_closed)
        else $error("the icache-closed flag rose outside reset");

endmodule

bind core_glue_top core_glue_sva u_core_glue_sva (
    .Clk             (Clk),
    .i_core_reset    (o_core_reset),
    .i_exception     (u_mem_request_router.i_exception),
    .i_cached        (u_mem_request_router.o_cached),
    .i_uncached      (u_mem_request_router.o_uncached),
    .i_icache_closed (u_cache_warmup_ctrl.icache_closed)
);

// File: verification/core_glue_tb.sv
`timescale 1ns/1ps

module core_glue_tb;
    import core_pkg::*;
    import bus_pkg::*;

    localparam int NUM_RANDOM  = 300;
    localparam int CYCLE_LIMIT = RESET_HOLD_CYCLES + NUM_RANDOM + 64;

    logic          Clk = 1'b0;
    logic          Myreset;
    logic          i_fetch_done;
    logic          i_dcache_closed;
    mem_req_t      i_req;
    logic          i_uncached;
    logic          i_exception;
    wb_t           i_wb;
    logic          i_flush;
    logic          i_dm_stall;
    logic          o_core_reset;
    logic          o_uncache_all;
    cached_req_t   o_cached;
    uncached_req_t o_uncached;
    cache_op_e     o_cache_op;
    logic          o_align_err;
    trace_t        o_trace;
    logic          checking = 1'b0;
    logic          trace_armed = 1'b0;
    trace_t        exp_trace;
    int            errors = 0;
    int            cycles = 0;
    logic [15:0]   lfsr = 16'd36;

    core_glue_top i_dut (.*);

    always #20 Clk = ~Clk;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ########################################
    // reference model
    // ########################################

    function automatic void ref_route(input mem_req_t r, input logic to_unc, input logic exc,
                                      output cached_req_t c, output uncached_req_t u,
                                      output logic err, output cache_op_e cop);
        logic    ld;
        logic    st;
        int      nbytes;
        int      off;
        byteen_t be;
        word_t   d;
        ld = r.op >= OP_LB && r.op <= OP_LL;
        st = r.op >= OP_SB && r.op <= OP_SC;
        case (r.op)
            OP_LW, OP_LL, OP_SW, OP_SC: nbytes = 4;
            OP_LH, OP_LHU, OP_SH:       nbytes = 2;
            default:                    nbytes = 1;
        endcase
        off = r.vaddr[1:0];
        for (int i = 0; i < 4; i++) begin
            be[i]       = (i >= off) && (i < off + nbytes);
            d[8*i +: 8] = r.wdata[8*(i % nbytes) +: 8];
        end
        err = (ld || st) && (off % nbytes != 0);
        c   = '0;
        u   = '0;
        if ((ld || st) && !err && !exc) begin
            if (to_unc) begin
                u = '{read: ld, write: st, size: access_size_e'(nbytes / 2), byteen: be,
                      paddr: r.paddr, wdata: d};
            end else begin
                c = '{read: ld, write: st, byteen: be, vaddr: r.vaddr, paddr: r.paddr, wdata: d};
            end
        end
        cop = COP_NONE;
        if (r.op == OP_CACHE) begin
            cop = (r.cache_field == 3'd0) ? COP_INDEX_INVALIDATE :
                  (r.cache_field == 3'd2) ? COP_STORE_TAG : COP_HIT_WRITEBACK;
        end
    endfunction

    function automatic trace_t ref_trace(input wb_t wb, input logic flush, input logic stall,
                                         input logic exc);
        trace_t t;
        t = '0;
        if (!flush) begin
            t.pc    = wb.pc;
            t.wnum  = wb.reg_id;
            t.wdata = wb.data;
            t.wen   = (wb.wen && (!stall || exc)) ? 4'hf : 4'h0;
        end
        return t;
    endfunction

    task automatic check_cached(input string name, input cached_req_t act, input cached_req_t exp);
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_uncached(input string name, input uncached_req_t act,
                                  input uncached_req_t exp);
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_trace(input string name, input trace_t act, input trace_t exp);
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, act, exp);
        end
    endtask

    task automatic check_cache_op(input string name, input cache_op_e act, input cache_op_e exp);
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0d, expected %0d", $time, name, act, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %b, expected %b", $time, name, act, exp);
        end
    endtask

    // outputs are compared mid-cycle, the trace one cycle after its inputs.
    always @(negedge Clk) begin
        cached_req_t   exp_c;
        uncached_req_t exp_u;
        logic          exp_err;
        cache_op_e     exp_cop;
        if (checking) begin
            ref_route(i_req, i_uncached | i_dcache_closed, i_exception, exp_c, exp_u, exp_err,
                      exp_cop);
            check_cached("o_cached", o_cached, exp_c);
            check_uncached("o_uncached", o_uncached, exp_u);
            check_flag("o_align_err", o_align_err, exp_err);
            check_cache_op("o_cache_op", o_cache_op, exp_cop);
            check_flag("o_uncache_all", o_uncache_all, i_dcache_closed);
            if (trace_armed) begin
                check_trace("o_trace", o_trace, exp_trace);
            end
        end
        exp_trace   = ref_trace(i_wb, i_flush, i_dm_stall, i_exception);
        trace_armed = checking;
    end

    always @(posedge Clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles before the tests were done", cycles);
            $display("errors: %0d", errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ########################################
    // stimulus
    // ########################################

    initial begin
        int    edges;
        int    op_sel;
        word_t va;
        word_t wd;
        word_t wb_head;
        Myreset         = 1'b1;
        i_fetch_done    = 1'b0;
        i_dcache_closed = 1'b0;
        i_req           = '0;
        i_uncached      = 1'b0;
        i_exception     = 1'b0;
        i_wb            = '0;
        i_flush         = 1'b0;
        i_dm_stall      = 1'b0;
        repeat (2) @(posedge Clk);
        Myreset <= 1'b0;
        edges = 0;
        do begin
            @(posedge Clk);
            edges++;
            @(negedge Clk);
        end while (o_core_reset);
        if (edges != RESET_HOLD_CYCLES) begin
            errors++;
            $display("FAILED t=%0t o_core_reset: held %0d edges, expected %0d", $time, edges,
                     RESET_HOLD_CYCLES);
        end
        // the loop leaves off on the edge that samples the third pulse.
        repeat (3) begin
            @(posedge Clk);
            i_fetch_done <= 1'b1;
            @(posedge Clk);
            i_fetch_done <= 1'b0;
        end
        edges = 0;
        do begin
            @(posedge Clk);
            edges++;
            @(negedge Clk);
        end while (o_uncache_all);
        if (edges != 2) begin
            errors++;
            $display("FAILED t=%0t o_uncache_all: fell after %0d edges, expected 2", $time, edges);
        end
        @(posedge Clk);
        i_dcache_closed <= 1'b1;
        @(negedge Clk);
        check_flag("o_uncache_all", o_uncache_all, 1'b1);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            @(posedge Clk);
            checking        <= 1'b1;
            op_sel          = lfsr_bits(4) % 10;
            va              = lfsr_bits(32);
            wd              = lfsr_bits(32);
            i_req           <= '{op: mem_op_e'(op_sel + 1), vaddr: va, paddr: {3'b000, va[28:0]},
                                 wdata: wd, cache_field: va[31:29]};
            i_uncached      <= (lfsr_bits(1) != 0);
            i_exception     <= (lfsr_bits(3) == 0);
            i_dcache_closed <= (lfsr_bits(2) == 0);
            wb_head         = lfsr_bits(6);
            i_wb            <= '{wen: wb_head[5], reg_id: wb_head[4:0], data: lfsr_bits(32),
                                 pc: lfsr_bits(32)};
            i_flush         <= (lfsr_bits(3) == 0);
            i_dm_stall      <= (lfsr_bits(1) != 0);
        end
        for (int f = 0; f < 8; f++) begin
            @(posedge Clk);
            i_req <= '{op: OP_CACHE, vaddr: '0, paddr: '0, wdata: '0, cache_field: f[2:0]};
        end
        repeat (2) @(posedge Clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
